// ==== build.f ====
design/mcast_pkg.sv
design/cfg_if.sv
design/apb_cfg_regs.sv
design/ifmap_caster.sv
design/filter_buffer.sv
design/mac_pe.sv
design/pe_slot_top.sv
verification/tb_pe_slot.sv

// ==== design/apb_cfg_regs.sv ====
`timescale 1ns/1ps

module apb_cfg_regs import mcast_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    cfg_if.regs       cfg
);

    tag_t      id_q;
    ksize_t    ksize_q;
    logic      en_q;
    logic      flush_q;
    cnt_t      psum_cnt;
    logic      access;
    logic      hit_ctrl;
    logic      hit_ksize;
    logic      hit_status;
    logic      ksize_bad;
    logic      err;
    apb_data_t rdata;

    //////////////////////////////
    // Decode
    //////////////////////////////
    assign access     = psel && penable;
    assign hit_ctrl   = (paddr == ADDR_CTRL);
    assign hit_ksize  = (paddr == ADDR_KSIZE);
    assign hit_status = (paddr == ADDR_STATUS);

    // Legal kernel sizes are 1 to MAX_KSIZE
    assign ksize_bad = (pwdata == '0) || (pwdata > apb_data_t'(MAX_KSIZE));

    // Unmapped, STATUS write, or bad KSIZE value
    assign err = !(hit_ctrl || hit_ksize || hit_status)
              || (pwrite && hit_status)
              || (pwrite && hit_ksize && ksize_bad);

    // Zero wait states
    assign pready  = access;
    assign pslverr = access && err;

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_q    <= '0;
            en_q    <= 1'b0;
            ksize_q <= ksize_t'(1);
            flush_q <= 1'b0;
        end else begin
            // Flush lasts one cycle
            flush_q <= access && pwrite && hit_ctrl && pwdata[CTRL_FLUSH_BIT];
            if (access && pwrite && hit_ctrl) begin
                id_q <= pwdata[CTRL_ID_LSB +: TAG_W];
                en_q <= pwdata[CTRL_EN_BIT];
            end
            if (access && pwrite && hit_ksize && !ksize_bad) begin
                ksize_q <= pwdata[KSIZE_W-1:0];
            end
        end
    end

    // Psums delivered, wraps at 16 bits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            psum_cnt <= '0;
        end else if (cfg.psum_done) begin
            psum_cnt <= psum_cnt + 1'b1;
        end
    end

    // Read mux, flush bit always reads 0
    always_comb begin
        rdata = '0;
        if (hit_ctrl) begin
            rdata[CTRL_ID_LSB +: TAG_W] = id_q;
            rdata[CTRL_EN_BIT]          = en_q;
        end else if (hit_ksize) begin
            rdata[KSIZE_W-1:0] = ksize_q;
        end else if (hit_status) begin
            rdata[STAT_LOADED_BIT]          = cfg.loaded;
            rdata[STAT_CNT_LSB +: CNT_W]    = psum_cnt;
        end
    end

    // Bus stays quiet outside reads
    assign prdata = (psel && !pwrite) ? rdata : '0;

    assign cfg.id     = id_q;
    assign cfg.ksize  = ksize_q;
    assign cfg.enable = en_q;
    assign cfg.flush  = flush_q;

    // Needs two access phases back to back, not legal APB
    a_flush_pulse: assert property (@(posedge clk) disable iff (!rstn)
        cfg.flush |=> !cfg.flush);

endmodule

// ==== design/cfg_if.sv ====
`timescale 1ns/1ps

interface cfg_if import mcast_pkg::*; ();

    // Set by the register block
    tag_t   id;
    ksize_t ksize;
    logic   enable;
    logic   flush;      // one cycle pulse

    // Status back from the datapath
    logic   loaded;
    logic   psum_done;  // one cycle pulse per psum taken

    modport regs (output id, ksize, enable, flush, input loaded, psum_done);

    // Filter buffer needs the ID for its own tag filter
    modport fbuf (input id, ksize, flush, output loaded);

    // Shared by the MAC and the ifmap caster
    modport mac (input id, ksize, enable, flush, loaded, output psum_done);

endinterface

// ==== design/filter_buffer.sv ====
`timescale 1ns/1ps

module filter_buffer import mcast_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  filter_valid,
    input  tag_t  filter_tag,
    input  data_t filter_data,
    output logic  filter_ready,
    cfg_if.fbuf   cfg,
    input  widx_t w_idx,
    output data_t w_data
);

    fb_state_t state;
    ksize_t    wr_cnt;
    logic      match;
    logic      wr_en;
    logic      last_wr;
    data_t     weights [MAX_KSIZE];

    //////////////////////////////
    // Tag filter and accept
    //////////////////////////////
    assign match = (filter_tag == cfg.id);

    // Own words stall once full or while a flush is in progress
    assign filter_ready = !match || ((state != FB_FULL) && !cfg.flush);
    assign wr_en        = filter_valid && match && filter_ready;

    // Greater-or-equal so a smaller ksize mid-fill still terminates
    assign last_wr = (wr_cnt + 1'b1) >= cfg.ksize;

    //////////////////////////////
    // Load FSM
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= FB_EMPTY;
            wr_cnt <= '0;
        end else if (cfg.flush) begin
            state  <= FB_EMPTY;
            wr_cnt <= '0;
        end else begin
            case (state)
                FB_EMPTY, FB_FILL: begin
                    if (wr_en) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        state  <= last_wr ? FB_FULL : FB_FILL;
                    end
                end
                FB_FULL: begin
                    // Wait for the next flush
                    state <= FB_FULL;
                end
                default: begin
                    state <= FB_EMPTY;
                end
            endcase
        end
    end

    // Weight store filled from index 0 upward
    always_ff @(posedge clk) begin
        if (wr_en) begin
            weights[wr_cnt[WIDX_W-1:0]] <= filter_data;
        end
    end

    // Read port for the MAC
    assign w_data = weights[w_idx];

    // Rises the cycle after the last weight lands
    assign cfg.loaded = (state == FB_FULL);

    // Writes never run past the last weight entry
    a_no_write_full: assert property (@(posedge clk) disable iff (!rstn)
        wr_en |-> (wr_cnt < ksize_t'(MAX_KSIZE)));

endmodule

// ==== design/ifmap_caster.sv ====
`timescale 1ns/1ps

module ifmap_caster import mcast_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic ifmap_valid,
    input  tag_t ifmap_tag,
    input  data_t ifmap_data,
    output logic ifmap_ready,
    cfg_if.mac   cfg,
    output logic cast_valid,
    output data_t cast_data,
    input  logic cast_ready
);

    logic  match;
    logic  load;
    logic  out_valid;
    data_t out_data;

    //////////////////////////////
    // Tag filter
    //////////////////////////////
    assign match = (ifmap_tag == cfg.id);

    // Foreign words are always swallowed
    // Own words need room, either empty or draining this cycle
    assign ifmap_ready = !match || !out_valid || cast_ready;
    assign load        = ifmap_valid && match && ifmap_ready;

    //////////////////////////////
    // Output register
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (cast_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= ifmap_data;
        end
    end

    assign cast_valid = out_valid;
    assign cast_data  = out_data;

    // Held word may not change under back-pressure
    a_cast_stable: assert property (@(posedge clk) disable iff (!rstn)
        cast_valid && !cast_ready |=> cast_valid && $stable(cast_data));

endmodule

// ==== design/mac_pe.sv ====
`timescale 1ns/1ps

module mac_pe import mcast_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  cast_valid,
    input  data_t cast_data,
    output logic  cast_ready,
    cfg_if.mac    cfg,
    output widx_t w_idx,
    input  data_t w_data,
    output logic  psum_valid,
    output psum_t psum_data,
    input  logic  psum_ready
);

    widx_t idx;
    psum_t acc;
    psum_t prod;
    psum_t sum;
    logic  run;
    logic  last;
    logic  stall;
    logic  fire;
    logic  out_valid;
    psum_t out_data;

    //////////////////////////////
    // Window control
    //////////////////////////////
    assign run  = cfg.enable && cfg.loaded;
    assign last = ({1'b0, idx} + 1'b1) >= cfg.ksize;

    // Finishing a window needs a free output slot
    // A slot that drains this very cycle counts as free
    assign stall = last && out_valid && !psum_ready;

    // Flush cycle takes nothing
    assign cast_ready = run && !stall && !cfg.flush;
    assign fire       = cast_valid && cast_ready;

    // Weight n for word n
    assign w_idx = idx;

    // Signed 16x16, truncated to psum width
    assign prod = cast_data * w_data;
    assign sum  = acc + prod;

    //////////////////////////////
    // Accumulator
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            idx <= '0;
            acc <= '0;
        end else if (cfg.flush) begin
            idx <= '0;
            acc <= '0;
        end else if (fire) begin
            if (last) begin
                // Next window starts from zero right away
                idx <= '0;
                acc <= '0;
            end else begin
                idx <= idx + 1'b1;
                acc <= sum;
            end
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (fire && last) begin
            out_valid <= 1'b1;
        end else if (psum_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Survives a flush
    always_ff @(posedge clk) begin
        if (fire && last) begin
            out_data <= sum;
        end
    end

    assign psum_valid    = out_valid;
    assign psum_data     = out_data;
    assign cfg.psum_done = out_valid && psum_ready;

    // Held psum stays put until the sink takes it
    a_psum_stable: assert property (@(posedge clk) disable iff (!rstn)
        psum_valid && !psum_ready |=> psum_valid && $stable(psum_data));

endmodule

// ==== design/mcast_pkg.sv ====
package mcast_pkg;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////
    localparam int DATA_W    = 16;
    localparam int TAG_W     = 2;
    localparam int PSUM_W    = 32;
    localparam int MAX_KSIZE = 16;
    localparam int KSIZE_W   = 5;
    localparam int WIDX_W    = $clog2(MAX_KSIZE);

    // APB bus and status counter widths
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;
    localparam int CNT_W  = 16;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic signed [PSUM_W-1:0] psum_t;
    typedef logic [KSIZE_W-1:0]       ksize_t;
    typedef logic [WIDX_W-1:0]        widx_t;
    typedef logic [APB_AW-1:0]        apb_addr_t;
    typedef logic [APB_DW-1:0]        apb_data_t;
    typedef logic [CNT_W-1:0]         cnt_t;

    //////////////////////////////
    // Register map
    //////////////////////////////
    localparam apb_addr_t ADDR_CTRL   = 8'h00;
    localparam apb_addr_t ADDR_KSIZE  = 8'h04;
    localparam apb_addr_t ADDR_STATUS = 8'h08;

    // CTRL fields
    localparam int CTRL_ID_LSB    = 0;
    localparam int CTRL_EN_BIT    = 4;
    localparam int CTRL_FLUSH_BIT = 8;

    // STATUS fields
    localparam int STAT_LOADED_BIT = 0;
    localparam int STAT_CNT_LSB    = 16;

    // Filter buffer load progress
    typedef enum logic [1:0] {
        FB_EMPTY,
        FB_FILL,
        FB_FULL
    } fb_state_t;

endpackage

// ==== design/pe_slot_top.sv ====
`timescale 1ns/1ps

module pe_slot_top import mcast_pkg::*; (
    input  logic      clk,
    input  logic      rstn,

    // APB slave
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,

    // Tagged ifmap stream
    input  logic      ifmap_valid,
    output logic      ifmap_ready,
    input  tag_t      ifmap_tag,
    input  data_t     ifmap_data,

    // Tagged filter stream
    input  logic      filter_valid,
    output logic      filter_ready,
    input  tag_t      filter_tag,
    input  data_t     filter_data,

    // Psum out
    output logic      psum_valid,
    input  logic      psum_ready,
    output psum_t     psum_data
);

    // Caster to MAC
    logic  cast_valid;
    logic  cast_ready;
    data_t cast_data;

    // MAC weight lookup
    widx_t w_idx;
    data_t w_data;

    cfg_if cfg ();

    //////////////////////////////
    // Config and status
    //////////////////////////////
    apb_cfg_regs u_regs (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg.regs)
    );

    //////////////////////////////
    // Datapath
    //////////////////////////////
    ifmap_caster u_caster (
        .clk         (clk),
        .rstn        (rstn),
        .ifmap_valid (ifmap_valid),
        .ifmap_tag   (ifmap_tag),
        .ifmap_data  (ifmap_data),
        .ifmap_ready (ifmap_ready),
        .cfg         (cfg.mac),
        .cast_valid  (cast_valid),
        .cast_data   (cast_data),
        .cast_ready  (cast_ready)
    );

    filter_buffer u_fbuf (
        .clk          (clk),
        .rstn         (rstn),
        .filter_valid (filter_valid),
        .filter_tag   (filter_tag),
        .filter_data  (filter_data),
        .filter_ready (filter_ready),
        .cfg          (cfg.fbuf),
        .w_idx        (w_idx),
        .w_data       (w_data)
    );

    mac_pe u_mac (
        .clk        (clk),
        .rstn       (rstn),
        .cast_valid (cast_valid),
        .cast_data  (cast_data),
        .cast_ready (cast_ready),
        .cfg        (cfg.mac),
        .w_idx      (w_idx),
        .w_data     (w_data),
        .psum_valid (psum_valid),
        .psum_data  (psum_data),
        .psum_ready (psum_ready)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the pe_slot testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pe_slot -f build.f -o sim_pe_slot

status=0
./obj_dir/sim_pe_slot > sim.log 2>&1 || status=$?
cat sim.log
[ "$status" -eq 0 ] || exit "$status"

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

// ==== verification/tb_pe_slot.sv ====
`timescale 1ns/1ps

module tb_pe_slot import mcast_pkg::*; ();

    localparam int TMO = 200;

    logic      clk;
    logic      rstn;
    logic      psel, penable, pwrite, pready, pslverr;
    apb_addr_t paddr;
    apb_data_t pwdata, prdata;
    logic      ifmap_valid, ifmap_ready, filter_valid, filter_ready;
    tag_t      ifmap_tag, filter_tag;
    data_t     ifmap_data, filter_data;
    logic      psum_valid, psum_ready;
    psum_t     psum_data;

    // Run bookkeeping
    integer    seed = 32'h4a4f2f2f;
    int        errors = 0;
    int        tests = 0;
    int        taken = 0;
    string     cur_test = "reset";
    logic      bp_on = 1'b0;
    logic      no_psum = 1'b0;

    // Reference model, one expected psum per finished window
    psum_t     exp_q[$];
    psum_t     exp_head = '0;
    logic      exp_avail = 1'b0;
    data_t     w_model [MAX_KSIZE];
    int        wcnt = 0;
    int        ksize_m = 1;
    tag_t      id_m = '0;
    psum_t     acc_m = '0;
    int        idx_m = 0;

    pe_slot_top dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    //////////////////////////////
    // Checkers
    //////////////////////////////

    // Queue head settled away from the rising edge
    always @(negedge clk) begin
        exp_avail = (exp_q.size() > 0);
        exp_head  = exp_avail ? exp_q[0] : '0;
    end

    // Retire one expected value per psum taken
    always @(posedge clk) begin
        if (rstn && psum_valid && psum_ready) begin
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            taken++;
        end
    end

    a_psum_expected: assert property (@(posedge clk) disable iff (!rstn)
        psum_valid && psum_ready |-> exp_avail)
        else begin
            errors++;
            $display("%s: psum taken while no window was expected", cur_test);
        end

    a_psum_value: assert property (@(posedge clk) disable iff (!rstn)
        psum_valid && psum_ready && exp_avail |-> psum_data == exp_head)
        else begin
            errors++;
            $display("error %s: psum expected %0d, actual %0d",
                     cur_test, exp_head, $sampled(psum_data));
        end

    // Stalled psum must wait unchanged
    a_psum_hold: assert property (@(posedge clk) disable iff (!rstn)
        psum_valid && !psum_ready |=> psum_valid && $stable(psum_data))
        else begin
            errors++;
            $display("%s: psum dropped or changed while stalled", cur_test);
        end

    a_enable_off: assert property (@(posedge clk) disable iff (!rstn)
        no_psum |-> !psum_valid)
        else begin
            errors++;
            $display("%s: psum appeared while enable was off", cur_test);
        end

    // Psum sink, random stalls when back-pressure is on
    initial begin
        psum_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            psum_ready = bp_on ? (($random(seed) % 3) != 0) : 1'b1;
        end
    end

    //////////////////////////////
    // Tasks
    //////////////////////////////

    task automatic check_value(input string what, input apb_data_t exp, input apb_data_t act);
        assert (act == exp) else begin
            errors++;
            $display("error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
        end
    endtask

    // One APB transfer, pslverr checked in the access phase
    task automatic bus_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              input logic exp_err, output apb_data_t rdata);
        int   n;
        logic rdy;
        logic err;
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        rdy    = 1'b0;
        err    = 1'b0;
        rdata  = '0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        for (n = 0; n < TMO && !rdy; n++) begin
            @(negedge clk);
            rdy   = pready;
            err   = pslverr;
            rdata = prdata;
            @(posedge clk);
            #1;
        end
        psel    = 1'b0;
        penable = 1'b0;
        if (!rdy) begin
            errors++;
            $display("%s: no pready on APB access to %0h", cur_test, addr);
        end
        check_value("pslverr", apb_data_t'(exp_err), apb_data_t'(err));
    endtask

    task automatic write_ctrl(input tag_t id, input logic en, input logic flush);
        apb_data_t v;
        apb_data_t rd;
        v = '0;
        v[CTRL_ID_LSB +: TAG_W] = id;
        v[CTRL_EN_BIT]          = en;
        v[CTRL_FLUSH_BIT]       = flush;
        bus_access(1'b1, ADDR_CTRL, v, 1'b0, rd);
        id_m = id;
    endtask

    // Half the words carry this slot's tag
    function automatic tag_t pick_tag();
        return (($random(seed) % 2) == 0) ? id_m : tag_t'($random(seed));
    endfunction

    // One stream word, held until the slot takes it
    task automatic send_word(input logic to_filter, input tag_t tag, input data_t data);
        int   n;
        logic rdy;
        ifmap_valid  = !to_filter;
        filter_valid = to_filter;
        ifmap_tag    = tag;
        filter_tag   = tag;
        ifmap_data   = data;
        filter_data  = data;
        rdy          = 1'b0;
        for (n = 0; n < TMO && !rdy; n++) begin
            @(negedge clk);
            rdy = to_filter ? filter_ready : ifmap_ready;
            @(posedge clk);
            #1;
        end
        ifmap_valid  = 1'b0;
        filter_valid = 1'b0;
        if (!rdy) begin
            errors++;
            $display("%s: stream word not accepted in time", cur_test);
        end else if (tag == id_m && to_filter) begin
            w_model[wcnt] = data;
            wcnt++;
        end else if (tag == id_m) begin
            // Word n of a window meets weight n
            acc_m = acc_m + psum_t'(data) * psum_t'(w_model[idx_m]);
            idx_m++;
            if (idx_m == ksize_m) begin
                exp_q.push_back(acc_m);
                acc_m = '0;
                idx_m = 0;
            end
        end
    endtask

    // New ID and kernel size, flush, then refill the weights
    task automatic set_kernel(input tag_t id, input int ks);
        apb_data_t rd;
        int        n;
        bus_access(1'b1, ADDR_KSIZE, apb_data_t'(ks), 1'b0, rd);
        write_ctrl(id, 1'b1, 1'b1);
        ksize_m = ks;
        acc_m   = '0;
        idx_m   = 0;
        wcnt    = 0;
        bus_access(1'b0, ADDR_STATUS, '0, 1'b0, rd);
        check_value("loaded after flush", '0, apb_data_t'(rd[STAT_LOADED_BIT]));
        for (n = 0; n < 400 && wcnt < ksize_m; n++) begin
            send_word(1'b1, pick_tag(), data_t'($random(seed)));
        end
        bus_access(1'b0, ADDR_STATUS, '0, 1'b0, rd);
        check_value("loaded after fill", 32'd1, apb_data_t'(rd[STAT_LOADED_BIT]));
    endtask

    task automatic send_windows(input int nwin);
        int   n;
        int   sent;
        tag_t t;
        sent = 0;
        for (n = 0; n < 4000 && sent < nwin * ksize_m; n++) begin
            t = pick_tag();
            send_word(1'b0, t, data_t'($random(seed)));
            if (t == id_m) begin
                sent++;
            end
        end
    endtask

    task automatic drain_psums();
        int n;
        for (n = 0; n < TMO && exp_q.size() > 0; n++) begin
            @(posedge clk);
            #1;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("%s: %0d expected psums never arrived", cur_test, exp_q.size());
        end
    endtask

    task automatic finish_test(input int e0);
        tests++;
        if (errors == e0) begin
            $display("test %s ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, errors - e0);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        int        e0;
        apb_data_t rd;
        rstn         = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        ifmap_valid  = 1'b0;
        ifmap_tag    = '0;
        ifmap_data   = '0;
        filter_valid = 1'b0;
        filter_tag   = '0;
        filter_data  = '0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;

        // Reset values, readback, bus errors
        cur_test = "reset_regs";
        e0 = errors;
        check_value("psum_valid", '0, apb_data_t'(psum_valid));
        check_value("pready", '0, apb_data_t'(pready));
        bus_access(1'b0, ADDR_KSIZE, '0, 1'b0, rd);
        check_value("ksize reset", 32'd1, rd);
        write_ctrl(2'd2, 1'b1, 1'b1);
        bus_access(1'b0, ADDR_CTRL, '0, 1'b0, rd);
        check_value("ctrl readback", 32'h12, rd);
        bus_access(1'b1, ADDR_KSIZE, 32'd9, 1'b0, rd);
        bus_access(1'b1, 8'h0c, 32'h5, 1'b1, rd);
        bus_access(1'b1, ADDR_STATUS, 32'h0, 1'b1, rd);
        bus_access(1'b1, ADDR_KSIZE, 32'h0, 1'b1, rd);
        bus_access(1'b0, ADDR_KSIZE, '0, 1'b0, rd);
        check_value("ksize readback", 32'd9, rd);
        finish_test(e0);

        // Only own-tag words count
        cur_test = "tag_multicast";
        e0 = errors;
        set_kernel(2'd1, 4);
        send_windows(6);
        drain_psums();
        finish_test(e0);

        cur_test = "back_pressure";
        e0 = errors;
        bp_on = 1'b1;
        send_windows(8);
        drain_psums();
        bp_on = 1'b0;
        finish_test(e0);

        // Largest kernel, other ID
        cur_test = "flush_reload";
        e0 = errors;
        set_kernel(2'd3, 16);
        send_windows(3);
        drain_psums();
        finish_test(e0);

        // Windows wait for enable, then the count must match
        cur_test = "enable_count";
        e0 = errors;
        write_ctrl(id_m, 1'b0, 1'b0);
        fork
            send_windows(3);
            begin
                no_psum = 1'b1;
                repeat (40) @(posedge clk);
                #1;
                no_psum = 1'b0;
                write_ctrl(id_m, 1'b1, 1'b0);
            end
        join
        drain_psums();
        bus_access(1'b0, ADDR_STATUS, '0, 1'b0, rd);
        check_value("psum count", apb_data_t'(taken), rd >> STAT_CNT_LSB);
        finish_test(e0);

        repeat (4) @(posedge clk);
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
